//--- src/mandel_macros.svh
// mandelbrot renderer constants
`ifndef MANDEL_MACROS_SVH
`define MANDEL_MACROS_SVH

// fixed point, signed 4.23
`define FIX_W 27
`define FIX_FRAC 23

// frame geometry and iteration cap
`define FRAME_W 32
`define FRAME_H 24
`define MAX_ITER 256

// credits, iterator queue depth and frame-store write slots
`define PT_CREDITS 2
`define PIX_CREDITS 4

// top-left corner of the view, -2.0 + 1.0i
`define CR_START (-(2 <<< `FIX_FRAC))
`define CI_START (1 <<< `FIX_FRAC)

// wide view spans 3.0 x 2.0
`define DX_WIDE ((3 <<< `FIX_FRAC) / `FRAME_W)
`define DY_WIDE ((2 <<< `FIX_FRAC) / `FRAME_H)
// zoomed view at half the step
`define DX_ZOOM (`DX_WIDE / 2)
`define DY_ZOOM (`DY_WIDE / 2)

// |z|^2 bound, 4.0 at full product scale
`define ESCAPE_LIMIT (54'sd4 <<< (2 * `FIX_FRAC))

// band colours, written red, green, blue
`define COLOR_IN_SET {3'd0, 3'd0, 2'd0}
`define COLOR_BAND_0 {3'd2, 3'd4, 2'd2}
`define COLOR_BAND_1 {3'd3, 3'd2, 2'd2}
`define COLOR_BAND_2 {3'd1, 3'd1, 2'd1}
`define COLOR_BAND_3 {3'd3, 3'd1, 2'd1}
`define COLOR_BAND_4 {3'd5, 3'd2, 2'd1}
`define COLOR_BAND_5 {3'd3, 3'd1, 2'd0}
`define COLOR_BAND_6 {3'd3, 3'd1, 2'd0}

`endif

//--- src/fix_pkg.sv
// fixed-point arithmetic types
`default_nettype none

`include "mandel_macros.svh"

package fix_pkg;

	//////////////////////////////////////////////////
	// value types
	//////////////////////////////////////////////////

	// signed 4.23 value
	typedef logic signed [`FIX_W-1:0] fix_t;

	// full product of two 4.23 values, 8.46
	typedef logic signed [2*`FIX_W-1:0] fix_wide_t;

	// 2.0, bailout bound on a single component
	localparam fix_t FIX_TWO = fix_t'(2 <<< `FIX_FRAC);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// exact product, operands sign extended first
	function automatic fix_wide_t fix_mul(input fix_t a, input fix_t b);
		return fix_wide_t'(a) * fix_wide_t'(b);
	endfunction

	// back to 4.23
	// arithmetic shift, then keep the low word
	function automatic fix_t fix_trunc(input fix_wide_t w);
		return fix_t'(w >>> `FIX_FRAC);
	endfunction

endpackage

`default_nettype wire

//--- src/frame_pkg.sv
// frame and pixel types
`default_nettype none

`include "mandel_macros.svh"

package frame_pkg;

	//////////////////////////////////////////////////
	// addressing
	//////////////////////////////////////////////////

	// pixels per frame
	localparam int PIX_N = `FRAME_W * `FRAME_H;

	// linear pixel index, row * FRAME_W + col
	typedef logic [$clog2(PIX_N)-1:0] pix_addr_t;

	// index of the final pixel in raster order
	localparam pix_addr_t PIX_LAST = pix_addr_t'(PIX_N - 1);

	// raster coordinates
	typedef logic [$clog2(`FRAME_W)-1:0] col_t;
	typedef logic [$clog2(`FRAME_H)-1:0] row_t;

	// escape count, 1 .. MAX_ITER
	typedef logic [$clog2(`MAX_ITER + 1)-1:0] iter_t;

	//////////////////////////////////////////////////
	// colour
	//////////////////////////////////////////////////

	// rgb332 fields, red in the top bits
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	// same byte, raw or by field
	typedef union packed {
		logic [7:0] raw;
		rgb332_t rgb;
	} color_u;

endpackage

`default_nettype wire

//--- src/point_if.sv
// candidate point link, sweep to iterator
`default_nettype none
`timescale 1ns/1ps

interface point_if;

	// one point per valid cycle
	logic pt_valid;
	// complex coordinate of the pixel
	fix_pkg::fix_t pt_cr;
	fix_pkg::fix_t pt_ci;
	// where the result lands
	frame_pkg::pix_addr_t pt_addr;
	// one pulse per queue pop, returns a credit
	logic pt_credit;

	// producer side
	modport sweep (
		output pt_valid,
		output pt_cr,
		output pt_ci,
		output pt_addr,
		input pt_credit
	);

	// consumer side
	modport iter (
		input pt_valid,
		input pt_cr,
		input pt_ci,
		input pt_addr,
		output pt_credit
	);

endinterface

`default_nettype wire

//--- src/pixel_sweep.sv
// raster sweep and frame timer
`default_nettype none
`timescale 1ns/1ps

`include "mandel_macros.svh"

module pixel_sweep (
	input logic clk,
	input logic rst,
	input logic start,
	input logic zoom,
	input logic last_pixel_out,
	point_if.sweep pt,
	output logic busy,
	output logic frame_done,
	output logic [31:0] frame_cycles
);

	localparam int PT_CW = $clog2(`PT_CREDITS + 1);
	localparam frame_pkg::col_t COL_LAST = frame_pkg::col_t'(`FRAME_W - 1);
	localparam frame_pkg::row_t ROW_LAST = frame_pkg::row_t'(`FRAME_H - 1);

	logic zoom_q;
	logic sweeping;
	logic launch;
	logic emit;
	frame_pkg::col_t col;
	frame_pkg::row_t row;
	frame_pkg::pix_addr_t addr;
	fix_pkg::fix_t cr;
	fix_pkg::fix_t ci;
	fix_pkg::fix_t dx;
	fix_pkg::fix_t dy;
	logic [PT_CW-1:0] credits;

	// a start while busy is ignored
	assign launch = start && !busy;
	// one point per cycle while a queue slot is free
	assign emit = sweeping && (credits != '0);

	// step size fixed for the whole frame
	assign dx = zoom_q ? fix_pkg::fix_t'(`DX_ZOOM) : fix_pkg::fix_t'(`DX_WIDE);
	assign dy = zoom_q ? fix_pkg::fix_t'(`DY_ZOOM) : fix_pkg::fix_t'(`DY_WIDE);

	assign pt.pt_valid = emit;
	assign pt.pt_cr = cr;
	assign pt.pt_ci = ci;
	assign pt.pt_addr = addr;

	//////////////////////////////////////////////////
	// frame status and timer
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			frame_done <= 1'b0;
			frame_cycles <= '0;
			zoom_q <= 1'b0;
		end else begin
			// done one cycle after the final pixel leaves
			frame_done <= busy && last_pixel_out;
			if (launch) begin
				busy <= 1'b1;
				zoom_q <= zoom;
				frame_cycles <= '0;
			end else if (busy) begin
				// counts the closing cycle too
				frame_cycles <= frame_cycles + 32'd1;
				if (last_pixel_out)
					busy <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// raster walk
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sweeping <= 1'b0;
			col <= '0;
			row <= '0;
			addr <= '0;
		end else if (launch) begin
			sweeping <= 1'b1;
			col <= '0;
			row <= '0;
			addr <= '0;
		end else if (emit) begin
			addr <= addr + 1'b1;
			if (col == COL_LAST) begin
				col <= '0;
				// last row sent, stop issuing
				if (row == ROW_LAST)
					sweeping <= 1'b0;
				else
					row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// point by accumulation, no multiply
	always_ff @(posedge clk) begin
		if (launch) begin
			cr <= fix_pkg::fix_t'(`CR_START);
			ci <= fix_pkg::fix_t'(`CI_START);
		end else if (emit) begin
			if (col == COL_LAST) begin
				// new row, back to left edge and one step down
				cr <= fix_pkg::fix_t'(`CR_START);
				ci <= ci - dy;
			end else begin
				cr <= cr + dx;
			end
		end
	end

	// credits toward the iterator queue
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credits <= PT_CW'(`PT_CREDITS);
		end else begin
			case ({emit, pt.pt_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	a_pt_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= PT_CW'(`PT_CREDITS));

	// never push into a queue with no free slot
	a_pt_valid_credit: assert property (@(posedge clk) disable iff (rst)
		pt.pt_valid |-> credits != '0);

endmodule

`default_nettype wire

//--- src/escape_iterator.sv
// escape-time iterator with point queue
`default_nettype none
`timescale 1ns/1ps

`include "mandel_macros.svh"

module escape_iterator (
	input logic clk,
	input logic rst,
	point_if.iter pt,
	output logic res_valid,
	output frame_pkg::pix_addr_t res_addr,
	output frame_pkg::iter_t res_iter,
	input logic res_ready
);

	localparam int QD = `PT_CREDITS;
	localparam int QW = $clog2(QD + 1);
	localparam int PW = (QD > 1) ? $clog2(QD) : 1;

	// queue storage
	fix_pkg::fix_t q_cr [QD];
	fix_pkg::fix_t q_ci [QD];
	frame_pkg::pix_addr_t q_addr [QD];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [QW-1:0] q_count;
	logic push;
	logic pop;

	// engine state
	logic running;
	fix_pkg::fix_t zr;
	fix_pkg::fix_t zi;
	fix_pkg::fix_t cr;
	fix_pkg::fix_t ci;
	fix_pkg::fix_wide_t zr_sq;
	fix_pkg::fix_wide_t zi_sq;
	frame_pkg::iter_t n;
	frame_pkg::pix_addr_t addr;

	// next-step values
	fix_pkg::fix_t zr_n;
	fix_pkg::fix_t zi_n;
	fix_pkg::fix_wide_t p_rzi;
	fix_pkg::fix_wide_t zr_sq_n;
	fix_pkg::fix_wide_t zi_sq_n;
	fix_pkg::fix_wide_t mag_sq;
	frame_pkg::iter_t n_next;
	logic escaped;
	logic at_cap;

	//////////////////////////////////////////////////
	// point queue
	//////////////////////////////////////////////////
	assign push = pt.pt_valid;
	// engine idle and no result waiting
	assign pop = (q_count != '0) && !running && !res_valid;
	assign pt.pt_credit = pop;

	always_ff @(posedge clk) begin
		if (push) begin
			q_cr[wr_ptr] <= pt.pt_cr;
			q_ci[wr_ptr] <= pt.pt_ci;
			q_addr[wr_ptr] <= pt.pt_addr;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(QD - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(QD - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: q_count <= q_count + 1'b1;
				2'b01: q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// z = z^2 + c
	//////////////////////////////////////////////////
	// squares of z carried from the previous step
	assign zr_n = fix_pkg::fix_trunc(zr_sq) - fix_pkg::fix_trunc(zi_sq) + cr;
	assign p_rzi = fix_pkg::fix_mul(zr, zi);
	assign zi_n = (fix_pkg::fix_trunc(p_rzi) <<< 1) + ci;
	assign zr_sq_n = fix_pkg::fix_mul(zr_n, zr_n);
	assign zi_sq_n = fix_pkg::fix_mul(zi_n, zi_n);
	assign mag_sq = zr_sq_n + zi_sq_n;
	assign n_next = n + 1'b1;

	// any component past +-2, or |z|^2 above 4
	assign escaped = (zr_n >= fix_pkg::FIX_TWO) || (zr_n <= -fix_pkg::FIX_TWO) ||
		(zi_n >= fix_pkg::FIX_TWO) || (zi_n <= -fix_pkg::FIX_TWO) ||
		(mag_sq > `ESCAPE_LIMIT);
	assign at_cap = (n_next == frame_pkg::iter_t'(`MAX_ITER));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			running <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			if (pop) begin
				running <= 1'b1;
			end else if (running && (escaped || at_cap)) begin
				running <= 1'b0;
				res_valid <= 1'b1;
			end
			// held until color_map takes it
			if (res_valid && res_ready)
				res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			// z starts at zero
			zr <= '0;
			zi <= '0;
			zr_sq <= '0;
			zi_sq <= '0;
			n <= '0;
			cr <= q_cr[rd_ptr];
			ci <= q_ci[rd_ptr];
			addr <= q_addr[rd_ptr];
		end else if (running) begin
			zr <= zr_n;
			zi <= zi_n;
			zr_sq <= zr_sq_n;
			zi_sq <= zi_sq_n;
			n <= n_next;
		end
	end

	assign res_addr = addr;
	assign res_iter = n;

	// the sweep's credit count keeps the queue in bounds
	a_queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
		pt.pt_valid |-> q_count < QW'(QD));

endmodule

`default_nettype wire

//--- src/color_map.sv
// iteration count to rgb332, frame-store writes
`default_nettype none
`timescale 1ns/1ps

`include "mandel_macros.svh"

module color_map (
	input logic clk,
	input logic rst,
	input logic res_valid,
	input frame_pkg::pix_addr_t res_addr,
	input frame_pkg::iter_t res_iter,
	input logic pix_credit,
	output logic res_ready,
	output logic pix_valid,
	output frame_pkg::pix_addr_t pix_addr,
	output logic [7:0] pix_color,
	output logic last_pixel_out
);

	localparam int SLOT_W = $clog2(`PIX_CREDITS + 1);

	logic hold_valid;
	frame_pkg::pix_addr_t hold_addr;
	frame_pkg::color_u hold_color;
	logic [SLOT_W-1:0] slots;
	logic accept;

	//////////////////////////////////////////////////
	// band table
	//////////////////////////////////////////////////
	// bands at MAX_ITER/2, /4 ... /64
	function automatic frame_pkg::color_u band_color(input frame_pkg::iter_t it);
		frame_pkg::color_u c;
		if (it == frame_pkg::iter_t'(`MAX_ITER))
			c.rgb = `COLOR_IN_SET;
		else if (it >= frame_pkg::iter_t'(`MAX_ITER >> 1))
			c.rgb = `COLOR_BAND_6;
		else if (it >= frame_pkg::iter_t'(`MAX_ITER >> 2))
			c.rgb = `COLOR_BAND_5;
		else if (it >= frame_pkg::iter_t'(`MAX_ITER >> 3))
			c.rgb = `COLOR_BAND_4;
		else if (it >= frame_pkg::iter_t'(`MAX_ITER >> 4))
			c.rgb = `COLOR_BAND_3;
		else if (it >= frame_pkg::iter_t'(`MAX_ITER >> 5))
			c.rgb = `COLOR_BAND_2;
		else if (it >= frame_pkg::iter_t'(`MAX_ITER >> 6))
			c.rgb = `COLOR_BAND_1;
		else
			c.rgb = `COLOR_BAND_0;
		return c;
	endfunction

	// send whenever a held pixel has a slot
	assign pix_valid = hold_valid && (slots != '0);
	// room if empty, or emptying this cycle
	assign res_ready = !hold_valid || pix_valid;
	assign accept = res_valid && res_ready;

	assign pix_addr = hold_addr;
	assign pix_color = hold_color.raw;
	assign last_pixel_out = pix_valid && (hold_addr == frame_pkg::PIX_LAST);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			hold_valid <= 1'b0;
		else if (accept)
			hold_valid <= 1'b1;
		else if (pix_valid)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			hold_addr <= res_addr;
			hold_color <= band_color(res_iter);
		end
	end

	// frame-store slots, one back per pix_credit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			slots <= SLOT_W'(`PIX_CREDITS);
		end else begin
			case ({pix_valid, pix_credit})
				2'b10: slots <= slots - 1'b1;
				2'b01: slots <= slots + 1'b1;
				default: slots <= slots;
			endcase
		end
	end

	// more returns than writes is a frame-store fault
	a_pix_slot_max: assert property (@(posedge clk) disable iff (rst)
		slots <= SLOT_W'(`PIX_CREDITS));

	a_pix_valid_slot: assert property (@(posedge clk) disable iff (rst)
		pix_valid |-> slots != '0);

endmodule

`default_nettype wire

//--- src/mandel_top.sv
// mandelbrot frame renderer top
`default_nettype none
`timescale 1ns/1ps

module mandel_top (
	input logic clk,
	input logic rst,
	// frame control
	input logic start,
	input logic zoom,
	// frame-store write port
	output logic pix_valid,
	output frame_pkg::pix_addr_t pix_addr,
	output logic [7:0] pix_color,
	input logic pix_credit,
	// status
	output logic busy,
	output logic frame_done,
	output logic [31:0] frame_cycles
);

	//////////////////////////////////////////////////
	// stage links
	//////////////////////////////////////////////////
	point_if pt ();

	// iterator to colour mapper
	logic res_valid;
	logic res_ready;
	frame_pkg::pix_addr_t res_addr;
	frame_pkg::iter_t res_iter;
	// final pixel written, closes the frame
	logic last_pixel_out;

	// decode, walks the frame
	pixel_sweep pixel_sweep_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.zoom(zoom),
		.last_pixel_out(last_pixel_out),
		.pt(pt),
		.busy(busy),
		.frame_done(frame_done),
		.frame_cycles(frame_cycles)
	);

	// execute, one point at a time
	escape_iterator escape_iterator_inst (
		.clk(clk),
		.rst(rst),
		.pt(pt),
		.res_valid(res_valid),
		.res_addr(res_addr),
		.res_iter(res_iter),
		.res_ready(res_ready)
	);

	// result, colour and write out
	color_map color_map_inst (
		.clk(clk),
		.rst(rst),
		.res_valid(res_valid),
		.res_addr(res_addr),
		.res_iter(res_iter),
		.pix_credit(pix_credit),
		.res_ready(res_ready),
		.pix_valid(pix_valid),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.last_pixel_out(last_pixel_out)
	);

endmodule

`default_nettype wire

//--- dv/mandel_tb.sv
// mandelbrot renderer testbench
`default_nettype none
`timescale 1ns/1ps

`include "mandel_macros.svh"

module mandel_tb;

	localparam int PIX_N = `FRAME_W * `FRAME_H;
	localparam int FRAMES = 3;
	localparam longint CLK_NS = 4;
	// per pixel, worst iteration count plus queue, handshake and credit stalls
	localparam longint WATCHDOG_NS = FRAMES * PIX_N * (`MAX_ITER + 64) * CLK_NS + 1000;

	logic clk;
	logic rst;
	logic start;
	logic zoom;
	logic pix_credit;
	logic pix_valid;
	frame_pkg::pix_addr_t pix_addr;
	logic [7:0] pix_color;
	logic busy;
	logic frame_done;
	logic [31:0] frame_cycles;

	// reference colours, one array per zoom setting
	logic [7:0] exp_color [2][PIX_N];

	string cur_test;
	int checks;
	int errors;
	int tests_run;
	int tests_failed;
	int test_errors0;
	int test_checks0;
	// scoreboard state
	int next_addr;
	int done_count;
	int pv_total;
	int pc_total;
	int credits_given;
	int hold_left;
	bit zoom_sel;
	bit throttle;
	longint cyc = 0;
	longint start_cyc;
	logic [31:0] rnd;

	mandel_top mandel_top_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.zoom(zoom),
		.pix_valid(pix_valid),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.pix_credit(pix_credit),
		.busy(busy),
		.frame_done(frame_done),
		.frame_cycles(frame_cycles)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// free-running cycle count for the frame timer check
	always @(posedge clk)
		cyc <= cyc + 1;

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// low 27 bits, sign extended
	function automatic longint fix_wrap(input longint v);
		longint w;
		w = v & ((longint'(1) << `FIX_W) - 1);
		if (w >= (longint'(1) << (`FIX_W - 1)))
			w = w - (longint'(1) << `FIX_W);
		return w;
	endfunction

	// full product, scaled back to 4.23
	function automatic longint fix_mul_trunc(input longint a, input longint b);
		return fix_wrap((a * b) >>> `FIX_FRAC);
	endfunction

	function automatic int escape_count(input longint cr, input longint ci);
		longint zr;
		longint zi;
		longint nr;
		longint ni;
		longint two;
		longint lim;
		int n;
		bit done;
		zr = 0;
		zi = 0;
		two = longint'(2) << `FIX_FRAC;
		lim = longint'(4) << (2 * `FIX_FRAC);
		n = 0;
		done = 1'b0;
		while (!done) begin
			nr = fix_wrap(fix_mul_trunc(zr, zr) - fix_mul_trunc(zi, zi) + cr);
			ni = fix_wrap(2 * fix_mul_trunc(zr, zi) + ci);
			n++;
			// component out of +-2, |z|^2 past 4, or cap
			if (nr >= two || nr <= -two || ni >= two || ni <= -two)
				done = 1'b1;
			else if (nr * nr + ni * ni > lim)
				done = 1'b1;
			else if (n == `MAX_ITER)
				done = 1'b1;
			zr = nr;
			zi = ni;
		end
		return n;
	endfunction

	// rgb332 band table
	function automatic logic [7:0] band_hex(input int n);
		if (n == `MAX_ITER)
			return 8'h00;
		else if (n >= 128)
			return 8'h64;
		else if (n >= 64)
			return 8'h64;
		else if (n >= 32)
			return 8'hA9;
		else if (n >= 16)
			return 8'h65;
		else if (n >= 8)
			return 8'h25;
		else if (n >= 4)
			return 8'h6A;
		return 8'h52;
	endfunction

	task automatic build_model();
		longint cr;
		longint ci;
		longint dx;
		longint dy;
		int z;
		int row;
		int col;
		for (z = 0; z < 2; z++) begin
			dx = (z != 0) ? `DX_ZOOM : `DX_WIDE;
			dy = (z != 0) ? `DY_ZOOM : `DY_WIDE;
			for (row = 0; row < `FRAME_H; row++) begin
				for (col = 0; col < `FRAME_W; col++) begin
					// top-left corner, columns right, rows down
					cr = `CR_START + col * dx;
					ci = `CI_START - row * dy;
					exp_color[z][row * `FRAME_W + col] = band_hex(escape_count(cr, ci));
				end
			end
		end
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	//////////////////////////////////////////////////
	// checks and reporting
	//////////////////////////////////////////////////

	task automatic check_value(input string what, input longint expected, input longint actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("Error %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s: %s", cur_test, what);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors0 = errors;
		test_checks0 = checks;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != test_errors0) begin
			tests_failed++;
			$display("FAIL %s, %0d errors", cur_test, errors - test_errors0);
		end else begin
			$display("PASS %s, %0d checks", cur_test, checks - test_checks0);
		end
	endtask

	// frame_done closes the frame, busy already low
	a_done_idle: assert property (@(posedge clk) disable iff (rst) frame_done |-> !busy)
	else begin
		errors++;
		$display("%s: busy still high while frame_done pulses", cur_test);
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) frame_done |=> !frame_done)
	else begin
		errors++;
		$display("%s: frame_done held longer than one cycle", cur_test);
	end

	a_addr_range: assert property (@(posedge clk) disable iff (rst) pix_valid |-> pix_addr < PIX_N)
	else begin
		errors++;
		$display("%s: pixel address beyond the frame", cur_test);
	end

	// write port scoreboard, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (pix_valid)
				pv_total++;
			if (pix_credit)
				pc_total++;
			check_true(pv_total - pc_total <= `PIX_CREDITS,
				"more writes outstanding than frame-store slots");
			if (pix_valid) begin
				check_true(busy, "pixel written while the renderer is idle");
				// raster order, no gaps, no repeats
				check_value("pixel address", next_addr, pix_addr);
				if (pix_addr < PIX_N)
					check_value("colour", exp_color[zoom_sel][pix_addr], pix_color);
				next_addr++;
			end
			if (frame_done)
				done_count++;
		end
	end

	//////////////////////////////////////////////////
	// frame store model
	//////////////////////////////////////////////////
	// one slot back per cycle, random holds when throttled
	initial begin
		pix_credit = 1'b0;
		hold_left = 0;
		credits_given = 0;
		rnd = 32'h5e92e671;
		forever begin
			@(posedge clk);
			#1;
			pix_credit = 1'b0;
			if (hold_left > 0) begin
				hold_left--;
			end else if (pv_total > credits_given) begin
				rnd = lcg_step(rnd);
				if (throttle && rnd[31:30] == 2'b00) begin
					hold_left = int'(rnd[15:8] % 40);
				end else begin
					pix_credit = 1'b1;
					credits_given++;
				end
			end
		end
	end

	task automatic render_frame(input string name, input bit zm, input bit slow);
		longint cycles_seen;
		logic [31:0] cycles_held;
		begin_test(name);
		zoom_sel = zm;
		throttle = slow;
		next_addr = 0;
		done_count = 0;
		@(posedge clk);
		#1;
		start = 1'b1;
		zoom = zm;
		// edge that samples start
		start_cyc = cyc + 1;
		@(posedge clk);
		#1;
		start = 1'b0;
		// flipped after start, must not matter
		zoom = ~zm;
		@(negedge clk);
		while (!frame_done)
			@(negedge clk);
		cycles_seen = cyc - start_cyc;
		check_value("frame_cycles", cycles_seen, frame_cycles);
		check_true(frame_cycles >= PIX_N, "frame took fewer cycles than it has pixels");
		check_value("pixels before frame_done", PIX_N, next_addr);
		cycles_held = frame_cycles;
		repeat (4) @(negedge clk);
		check_value("frame_done pulses", 1, done_count);
		check_true(!busy, "busy high after frame_done");
		check_value("frame_cycles after frame", cycles_held, frame_cycles);
		end_test();
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin
		int i;
		rst = 1'b1;
		start = 1'b0;
		zoom = 1'b0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		pv_total = 0;
		pc_total = 0;
		zoom_sel = 1'b0;
		throttle = 1'b0;
		build_model();

		begin_test("reset_state");
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			#1;
			check_true(!pix_valid && !busy && !frame_done, "outputs active during reset");
		end
		rst = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#1;
			check_true(!pix_valid && !busy && !frame_done, "outputs active right after reset");
		end
		end_test();

		render_frame("wide_view", 1'b0, 1'b0);
		render_frame("zoom_view", 1'b1, 1'b0);
		render_frame("back_pressure", 1'b0, 1'b1);

		$display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: frames did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/fix_pkg.sv
src/frame_pkg.sv
src/point_if.sv
src/pixel_sweep.sv
src/escape_iterator.sv
src/color_map.sv
src/mandel_top.sv
dv/mandel_tb.sv

//--- run.sh
#!/bin/sh
# build and run the renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module mandel_tb -f verilog.f -o mandel_sim

# the log decides the result, not the exit code
./obj_dir/mandel_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
